//--- Bender.yml
package:
  name: branch_exec

dependencies: {}

sources:
  # Package first, then the stages and the top level
  - branch_pkg.sv
  - branch_issue_stage.sv
  - branch_compare_stage.sv
  - branch_resolve_stage.sv
  - branch_exec_top.sv
  # Testbench and bound assertions
  - target: simulation
    files:
      - branch_exec_assertions.sv
      - tb_branch_exec.sv

//--- branch_compare_stage.sv
// ********************
// Second pipeline stage of the branch path
// Evaluates the branch condition and forms target and link addresses
// ********************
module branch_compare_stage (
    // Core clock
    input  logic                         clk_i,
    // Synchronous reset, active high
    input  logic                         reset_i,
    // Classified operation from the issue stage
    input  branch_pkg::branch_issued_t   issued_i,
    // Registered condition and addresses
    output branch_pkg::branch_computed_t computed_o
);

    // Comparison results
    logic cmp_eq;
    logic cmp_lt_s;
    logic cmp_lt_u;
    logic cond_true;

    // Address arithmetic
    branch_pkg::xlen_t jump_base;
    branch_pkg::xlen_t target;
    branch_pkg::xlen_t link;

    branch_pkg::branch_computed_t computed_d;

    // One equality and two magnitude compares cover all six conditions
    assign cmp_eq   = issued_i.req.operand_a == issued_i.req.operand_b;
    assign cmp_lt_s = $signed(issued_i.req.operand_a) < $signed(issued_i.req.operand_b);
    assign cmp_lt_u = issued_i.req.operand_a < issued_i.req.operand_b;

    // Pick the compare the operation asks for
    always_comb begin
        case (issued_i.req.op)
            branch_pkg::OP_BEQ:  cond_true = cmp_eq;
            branch_pkg::OP_BNE:  cond_true = !cmp_eq;
            branch_pkg::OP_BLT:  cond_true = cmp_lt_s;
            branch_pkg::OP_BGE:  cond_true = !cmp_lt_s;
            branch_pkg::OP_BLTU: cond_true = cmp_lt_u;
            branch_pkg::OP_BGEU: cond_true = !cmp_lt_u;
            // Jumps ignore the condition
            default:             cond_true = 1'b0;
        endcase
    end

    // JALR jumps relative to rs1, everything else relative to pc
    assign jump_base = issued_i.is_jalr ? issued_i.req.operand_a : issued_i.req.pc;

    always_comb begin
        target = jump_base + issued_i.req.imm;
        // JALR drops the lowest bit of the sum
        if (issued_i.is_jalr) begin
            target[0] = 1'b0;
        end
    end

    // Return address, always one full instruction ahead
    assign link = issued_i.req.pc + branch_pkg::xlen_t'(branch_pkg::INSTR_BYTES);

    always_comb begin
        computed_d.valid       = issued_i.req.valid;
        computed_d.pc          = issued_i.req.pc;
        computed_d.is_cond     = issued_i.is_cond;
        computed_d.is_jalr     = issued_i.is_jalr;
        computed_d.cond_true   = cond_true;
        computed_d.target      = target;
        computed_d.link        = link;
        // Prediction rides along for the resolve stage
        computed_d.pred_cf     = issued_i.req.pred_cf;
        computed_d.pred_target = issued_i.req.pred_target;
    end

    // Stage register, valid cleared on reset
    always_ff @(posedge clk_i) begin
        computed_o <= computed_d;
        if (reset_i) begin
            computed_o.valid <= 1'b0;
        end
    end

endmodule

//--- branch_exec_assertions.sv
// ********************
// Concurrent checks on the branch pipeline outputs
// Bound into every branch_exec_top instance
// ********************
module branch_exec_assertions (
    input logic                         clk_i,
    input logic                         reset_i,
    input branch_pkg::branch_resolved_t resolved_i,
    input branch_pkg::branch_wb_t       wb_i,
    input branch_pkg::branch_exc_t      exc_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Pipeline needs three edges to refill after reset
    quiet_after_reset: assert property (@(posedge clk_i)
        $fell(reset_i) |-> (!resolved_i.valid && !wb_i.valid && !exc_i.valid) [*3])
        else $error("valid output within three cycles of reset");

    // Only a taken resolution can fault
    exc_needs_taken: assert property (@(posedge clk_i) disable iff (reset_i)
        exc_i.valid |-> resolved_i.valid && resolved_i.is_taken)
        else $error("exception without a taken resolution");

    // Link goes out with every resolution
    wb_follows_resolved: assert property (@(posedge clk_i) disable iff (reset_i)
        resolved_i.valid |-> wb_i.valid == resolved_i.valid)
        else $error("writeback valid differs from resolution valid");

endmodule

bind branch_exec_top branch_exec_assertions u_assertions (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .resolved_i (resolved_o),
    .wb_i       (wb_o),
    .exc_i      (exc_o)
);

//--- branch_exec_top.sv
// ********************
// Top of the branch execution path
// Issue, compare and resolve in a chain, three cycles from request to result
// ********************
module branch_exec_top (
    // Core clock
    input  logic                         clk_i,
    // Synchronous reset, active high
    input  logic                         reset_i,
    // Branch or jump from the issue logic, one per cycle
    input  branch_pkg::branch_req_t      req_i,
    // Resolution for the front end
    output branch_pkg::branch_resolved_t resolved_o,
    // Link writeback
    output branch_pkg::branch_wb_t       wb_o,
    // Misaligned target exception
    output branch_pkg::branch_exc_t      exc_o
);

    // Stage-to-stage registers
    branch_pkg::branch_issued_t   issued;
    branch_pkg::branch_computed_t computed;

    // Decode into classes
    branch_issue_stage u_issue (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (req_i),
        .issued_o (issued)
    );

    // Condition and addresses
    branch_compare_stage u_compare (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .issued_i   (issued),
        .computed_o (computed)
    );

    // Prediction check and exception
    branch_resolve_stage u_resolve (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .computed_i (computed),
        .resolved_o (resolved_o),
        .wb_o       (wb_o),
        .exc_o      (exc_o)
    );

endmodule

//--- branch_issue_stage.sv
// ********************
// First pipeline stage of the branch path
// Registers the request and sorts it into branch, jump or register jump
// ********************
module branch_issue_stage (
    // Core clock
    input  logic                       clk_i,
    // Synchronous reset, active high
    input  logic                       reset_i,
    // Incoming operation, qualified by its valid bit
    input  branch_pkg::branch_req_t    req_i,
    // Registered operation with class flags
    output branch_pkg::branch_issued_t issued_o
);

    branch_pkg::branch_issued_t issued_d;

    // Only decode of the opcode into classes
    always_comb begin
        issued_d.req     = req_i;
        issued_d.is_cond = 1'b0;
        issued_d.is_jalr = 1'b0;
        case (req_i.op)
            // Six compare-and-branch forms
            branch_pkg::OP_BEQ,
            branch_pkg::OP_BNE,
            branch_pkg::OP_BLT,
            branch_pkg::OP_BGE,
            branch_pkg::OP_BLTU,
            branch_pkg::OP_BGEU: begin
                issued_d.is_cond = 1'b1;
            end
            // Register-indirect jump
            branch_pkg::OP_JALR: begin
                issued_d.is_jalr = 1'b1;
            end
            // JAL leaves both flags clear
            default: begin
                issued_d.is_cond = 1'b0;
                issued_d.is_jalr = 1'b0;
            end
        endcase
    end

    // Stage register
    // Payload free-runs, only the valid bit is cleared by reset
    always_ff @(posedge clk_i) begin
        issued_o <= issued_d;
        if (reset_i) begin
            issued_o.req.valid <= 1'b0;
        end
    end

endmodule

//--- branch_pkg.sv
// ********************
// Shared widths, encodings and stage structs for the branch pipeline
// Every pipeline file refers to these by scoped name
// ********************
package branch_pkg;

    // Register and address width
    localparam int unsigned XLEN = 32;
    // No compressed instructions, so every instruction is one word
    localparam int unsigned INSTR_BYTES = 4;
    // Width of the exception cause field
    localparam int unsigned CAUSE_W = 4;
    // Instruction address misaligned cause code
    localparam logic [CAUSE_W-1:0] EXC_INSTR_ADDR_MISALIGNED = 4'd0;

    // One machine word
    typedef logic [XLEN-1:0] xlen_t;

    // Branch encodings follow funct3, jumps fill the two unused codes
    typedef enum logic [2:0] {
        OP_BEQ  = 3'b000,
        OP_BNE  = 3'b001,
        OP_JAL  = 3'b010,
        OP_JALR = 3'b011,
        OP_BLT  = 3'b100,
        OP_BGE  = 3'b101,
        OP_BLTU = 3'b110,
        OP_BGEU = 3'b111
    } branch_op_e;

    // Control-flow type as seen by the predictor
    typedef enum logic [2:0] {
        CF_NONE   = 3'd0,
        CF_BRANCH = 3'd1,
        CF_JUMP   = 3'd2,
        CF_JUMPR  = 3'd3,
        CF_RETURN = 3'd4
    } cf_type_e;

    // Operation entering the pipeline, imm already sign-extended
    typedef struct packed {
        logic       valid;
        branch_op_e op;
        xlen_t      pc;
        xlen_t      operand_a;
        xlen_t      operand_b;
        xlen_t      imm;
        cf_type_e   pred_cf;
        xlen_t      pred_target;
    } branch_req_t;

    // Request plus the decoded class flags
    typedef struct packed {
        branch_req_t req;
        logic        is_cond;
        logic        is_jalr;
    } branch_issued_t;

    // Condition result and the two candidate addresses
    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        logic     is_cond;
        logic     is_jalr;
        logic     cond_true;
        xlen_t    target;
        xlen_t    link;
        cf_type_e pred_cf;
        xlen_t    pred_target;
    } branch_computed_t;

    // Resolution sent back to the front end
    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        xlen_t    target;
        logic     is_taken;
        logic     is_mispredict;
        cf_type_e cf_type;
    } branch_resolved_t;

    // Exception report, tval holds the faulting pc
    typedef struct packed {
        logic               valid;
        logic [CAUSE_W-1:0] cause;
        xlen_t              tval;
    } branch_exc_t;

    // Link value for the register file
    typedef struct packed {
        logic  valid;
        xlen_t link;
    } branch_wb_t;

endpackage

//--- branch_resolve_stage.sv
// ********************
// Last pipeline stage of the branch path
// Checks the outcome against the prediction and raises misalignment
// Drives resolution, link writeback and exception to the core
// ********************
module branch_resolve_stage (
    // Core clock
    input  logic                         clk_i,
    // Synchronous reset, active high
    input  logic                         reset_i,
    // Condition and addresses from the compare stage
    input  branch_pkg::branch_computed_t computed_i,
    // Resolution for the front end
    output branch_pkg::branch_resolved_t resolved_o,
    // Link writeback
    output branch_pkg::branch_wb_t       wb_o,
    // Misaligned target exception
    output branch_pkg::branch_exc_t      exc_o
);

    logic                 is_taken;
    logic                 is_mispredict;
    logic                 misaligned;
    branch_pkg::cf_type_e cf_type;
    branch_pkg::xlen_t    next_pc;

    branch_pkg::branch_resolved_t resolved_d;
    branch_pkg::branch_wb_t       wb_d;
    branch_pkg::branch_exc_t      exc_d;

    // Jumps are always taken
    assign is_taken = computed_i.is_cond ? computed_i.cond_true : 1'b1;

    // Fall through to the link when not taken
    assign next_pc = is_taken ? computed_i.target : computed_i.link;

    // Prediction check and predictor update type
    always_comb begin
        // JAL keeps whatever the front end predicted
        cf_type       = computed_i.pred_cf;
        is_mispredict = 1'b0;
        if (computed_i.is_cond) begin
            // Predictor learns every conditional branch
            cf_type       = branch_pkg::CF_BRANCH;
            is_mispredict = is_taken != (computed_i.pred_cf == branch_pkg::CF_BRANCH);
        end else if (computed_i.is_jalr) begin
            // No prediction at all, or a wrong target
            if (computed_i.pred_cf == branch_pkg::CF_NONE ||
                computed_i.target != computed_i.pred_target) begin
                is_mispredict = 1'b1;
                // Returns stay with the return stack, not the BTB
                if (computed_i.pred_cf != branch_pkg::CF_RETURN) begin
                    cf_type = branch_pkg::CF_JUMPR;
                end
            end
        end
    end

    // Any low address bit set within one instruction word
    assign misaligned =
        |(computed_i.target & branch_pkg::xlen_t'(branch_pkg::INSTR_BYTES - 1));

    always_comb begin
        resolved_d.valid         = computed_i.valid;
        resolved_d.pc            = computed_i.pc;
        resolved_d.target        = next_pc;
        resolved_d.is_taken      = is_taken;
        resolved_d.is_mispredict = is_mispredict;
        resolved_d.cf_type       = cf_type;

        // Link goes out for every operation, the core drops it for branches
        wb_d.valid = computed_i.valid;
        wb_d.link  = computed_i.link;

        // Only a taken target can fault
        exc_d.valid = computed_i.valid && is_taken && misaligned;
        exc_d.cause = branch_pkg::EXC_INSTR_ADDR_MISALIGNED;
        exc_d.tval  = computed_i.pc;
    end

    // Output registers
    // One-cycle pulses, there is no way to stall the consumer
    always_ff @(posedge clk_i) begin
        resolved_o <= resolved_d;
        wb_o       <= wb_d;
        exc_o      <= exc_d;
        if (reset_i) begin
            resolved_o.valid <= 1'b0;
            wb_o.valid       <= 1'b0;
            exc_o.valid      <= 1'b0;
        end
    end

endmodule

//--- src.f
branch_pkg.sv
branch_issue_stage.sv
branch_compare_stage.sv
branch_resolve_stage.sv
branch_exec_top.sv
branch_exec_assertions.sv
tb_branch_exec.sv

//--- tb_branch_exec.sv
// ********************
// Table-driven testbench for the branch execution pipeline
// Drives one row per cycle and checks each result three cycles later
// ********************
module tb_branch_exec;
    timeunit 1ns;
    timeprecision 100ps;

    // Table size and fixed pipeline depth
    localparam int MAX_ROWS      = 32;
    localparam int LATENCY       = 3;
    localparam int DRAIN_TIMEOUT = 10;

    // Hand-derived expected result of one row
    typedef struct packed {
        branch_pkg::xlen_t    target;
        logic                 is_taken;
        logic                 is_mispredict;
        branch_pkg::cf_type_e cf_type;
        branch_pkg::xlen_t    link;
        logic                 exc_valid;
    } golden_t;

    logic                         clk_i;
    logic                         reset_i;
    branch_pkg::branch_req_t      req;
    branch_pkg::branch_resolved_t resolved;
    branch_pkg::branch_wb_t       wb;
    branch_pkg::branch_exc_t      exc;

    // Stimulus table
    string                   row_name [MAX_ROWS];
    branch_pkg::branch_req_t row_req  [MAX_ROWS];
    golden_t                 row_gold [MAX_ROWS];
    int                      row_count = 0;

    // Rows in flight and the cycle each one was driven in
    int pending_row   [$];
    int pending_cycle [$];

    int error_count = 0;
    int check_count = 0;
    int cycle_cnt   = 0;

    branch_exec_top uut (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .req_i      (req),
        .resolved_o (resolved),
        .wb_o       (wb),
        .exc_o      (exc)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Edge counter for latency checks
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic add_row(input string name, input branch_pkg::branch_op_e op,
                           input branch_pkg::xlen_t pc, input branch_pkg::xlen_t a,
                           input branch_pkg::xlen_t b, input branch_pkg::xlen_t imm,
                           input branch_pkg::cf_type_e pred_cf,
                           input branch_pkg::xlen_t pred_target,
                           input branch_pkg::xlen_t target, input logic taken,
                           input logic mispredict, input branch_pkg::cf_type_e cf,
                           input branch_pkg::xlen_t link, input logic exc_valid);
        row_name[row_count]                 = name;
        row_req[row_count]                  = '{1'b1, op, pc, a, b, imm, pred_cf, pred_target};
        row_gold[row_count]                 = '{target, taken, mispredict, cf, link, exc_valid};
        row_count++;
    endtask

    // Each row gives name, op, pc, rs1, rs2, imm, predicted type and target
    // followed by target, taken, mispredict, type, link and exception
    task automatic build_table();
        add_row("beq_misaligned", branch_pkg::OP_BEQ, 'h2600, 'h0, 'h0, 'h2,
                branch_pkg::CF_BRANCH, 'h2602, 'h2602, 1, 0, branch_pkg::CF_BRANCH, 'h2604, 1);
        add_row("bne_not_taken_misaligned", branch_pkg::OP_BNE, 'h2700, 'h0, 'h0, 'h2,
                branch_pkg::CF_NONE, 'h0, 'h2704, 0, 0, branch_pkg::CF_BRANCH, 'h2704, 0);
        add_row("bne_taken_back", branch_pkg::OP_BNE, 'h700, 'h1, 'h2, 'hFFFF_FF00,
                branch_pkg::CF_BRANCH, 'h600, 'h600, 1, 0, branch_pkg::CF_BRANCH, 'h704, 0);
        add_row("beq_not_taken", branch_pkg::OP_BEQ, 'h800, 'h1, 'h2, 'h10,
                branch_pkg::CF_NONE, 'h0, 'h804, 0, 0, branch_pkg::CF_BRANCH, 'h804, 0);
        add_row("blt_neg_taken", branch_pkg::OP_BLT, 'h300, 'hFFFF_FFF0, 'h1, 'hFFFF_FFF0,
                branch_pkg::CF_BRANCH, 'h2F0, 'h2F0, 1, 0, branch_pkg::CF_BRANCH, 'h304, 0);
        add_row("blt_not_taken", branch_pkg::OP_BLT, 'h900, 'h5, 'hFFFF_FFFB, 'h10,
                branch_pkg::CF_NONE, 'h0, 'h904, 0, 0, branch_pkg::CF_BRANCH, 'h904, 0);
        add_row("bltu_neg_not_taken", branch_pkg::OP_BLTU, 'h400, 'hFFFF_FFF0, 'h1, 'h10,
                branch_pkg::CF_NONE, 'h0, 'h404, 0, 0, branch_pkg::CF_BRANCH, 'h404, 0);
        add_row("bltu_taken", branch_pkg::OP_BLTU, 'hA00, 'h5, 'hFFFF_FFFB, 'h10,
                branch_pkg::CF_BRANCH, 'hA10, 'hA10, 1, 0, branch_pkg::CF_BRANCH, 'hA04, 0);
        add_row("bge_neg_mispredict", branch_pkg::OP_BGE, 'h500, 'hFFFF_FFFF, 'h0, 'h8,
                branch_pkg::CF_BRANCH, 'h508, 'h504, 0, 1, branch_pkg::CF_BRANCH, 'h504, 0);
        add_row("bge_equal_taken", branch_pkg::OP_BGE, 'hB00, 'h3, 'h3, 'h20,
                branch_pkg::CF_BRANCH, 'hB20, 'hB20, 1, 0, branch_pkg::CF_BRANCH, 'hB04, 0);
        add_row("bgeu_neg_mispredict", branch_pkg::OP_BGEU, 'h600, 'hFFFF_FFFF, 'h0, 'h8,
                branch_pkg::CF_NONE, 'h0, 'h608, 1, 1, branch_pkg::CF_BRANCH, 'h604, 0);
        add_row("bgeu_not_taken", branch_pkg::OP_BGEU, 'hC00, 'h1, 'h2, 'h20,
                branch_pkg::CF_NONE, 'h0, 'hC04, 0, 0, branch_pkg::CF_BRANCH, 'hC04, 0);
        add_row("jal_pred_jump", branch_pkg::OP_JAL, 'h1000, 'h0, 'h0, 'h100,
                branch_pkg::CF_JUMP, 'h1100, 'h1100, 1, 0, branch_pkg::CF_JUMP, 'h1004, 0);
        add_row("jal_misaligned", branch_pkg::OP_JAL, 'h2800, 'h0, 'h0, 'hA,
                branch_pkg::CF_NONE, 'h0, 'h280A, 1, 0, branch_pkg::CF_NONE, 'h2804, 1);
        add_row("jalr_hit", branch_pkg::OP_JALR, 'h2000, 'h3000, 'h0, 'h10,
                branch_pkg::CF_JUMPR, 'h3010, 'h3010, 1, 0, branch_pkg::CF_JUMPR, 'h2004, 0);
        add_row("jalr_wrong_target", branch_pkg::OP_JALR, 'h2100, 'h3000, 'h0, 'h20,
                branch_pkg::CF_JUMP, 'h3010, 'h3020, 1, 1, branch_pkg::CF_JUMPR, 'h2104, 0);
        add_row("jalr_return_miss", branch_pkg::OP_JALR, 'h2200, 'h4000, 'h0, 'h0,
                branch_pkg::CF_RETURN, 'h4100, 'h4000, 1, 1, branch_pkg::CF_RETURN, 'h2204, 0);
        add_row("jalr_no_prediction", branch_pkg::OP_JALR, 'h2300, 'h5000, 'h0, 'h4,
                branch_pkg::CF_NONE, 'h5004, 'h5004, 1, 1, branch_pkg::CF_JUMPR, 'h2304, 0);
        add_row("jalr_odd_sum", branch_pkg::OP_JALR, 'h2400, 'h6001, 'h0, 'h10,
                branch_pkg::CF_JUMPR, 'h6010, 'h6010, 1, 0, branch_pkg::CF_JUMPR, 'h2404, 0);
        add_row("jalr_misaligned", branch_pkg::OP_JALR, 'h2500, 'h7000, 'h0, 'h6,
                branch_pkg::CF_JUMPR, 'h7006, 'h7006, 1, 0, branch_pkg::CF_JUMPR, 'h2504, 1);
    endtask

    // Bubble with random don't-care payload
    task automatic drive_idle();
        req             = '0;
        req.op          = branch_pkg::branch_op_e'($urandom_range(7, 0));
        req.pc          = $urandom;
        req.operand_a   = $urandom;
        req.operand_b   = $urandom;
        req.imm         = $urandom;
        req.pred_target = $urandom;
    endtask

    task automatic check_result(input int idx, input int issued_at);
        string   n;
        golden_t g;
        n = row_name[idx];
        g = row_gold[idx];
        check_value({n, " latency"}, LATENCY, cycle_cnt - issued_at);
        check_value({n, " pc"}, row_req[idx].pc, resolved.pc);
        check_value({n, " target"}, g.target, resolved.target);
        check_value({n, " is_taken"}, g.is_taken, resolved.is_taken);
        check_value({n, " is_mispredict"}, g.is_mispredict, resolved.is_mispredict);
        check_value({n, " cf_type"}, g.cf_type, resolved.cf_type);
        check_value({n, " wb valid"}, 1, wb.valid);
        check_value({n, " wb link"}, g.link, wb.link);
        check_value({n, " exc valid"}, g.exc_valid, exc.valid);
        // Cause and tval only mean something with a live exception
        if (g.exc_valid) begin
            check_value({n, " exc cause"}, branch_pkg::EXC_INSTR_ADDR_MISALIGNED, exc.cause);
            check_value({n, " exc tval"}, row_req[idx].pc, exc.tval);
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk_i) begin : result_checker
        int idx;
        int issued_at;
        if (reset_i) begin
            check_value("reset resolved valid", 0, resolved.valid);
            check_value("reset wb valid", 0, wb.valid);
            check_value("reset exc valid", 0, exc.valid);
        end else begin
            check_value("wb valid follows resolved", resolved.valid, wb.valid);
            if (exc.valid) begin
                check_value("exc only on taken result", 1, resolved.valid && resolved.is_taken);
            end
            if (resolved.valid) begin
                if (pending_row.size() == 0) begin
                    $display("result seen with no operation in flight");
                    error_count++;
                end else begin
                    idx       = pending_row.pop_front();
                    issued_at = pending_cycle.pop_front();
                    check_result(idx, issued_at);
                end
            end
        end
    end

    initial begin : stimulus
        int drain_cycles;
        void'($urandom(75490));
        reset_i = 1'b1;
        req     = '0;
        build_table();
        repeat (2) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        for (int i = 0; i < row_count; i++) begin
            // Occasional idle cycle between rows
            if ($urandom_range(3, 0) == 0) begin
                drive_idle();
                @(posedge clk_i);
                #1;
            end
            req = row_req[i];
            pending_row.push_back(i);
            pending_cycle.push_back(cycle_cnt);
            @(posedge clk_i);
            #1;
        end
        drive_idle();
        // Let the last rows drain
        drain_cycles = 0;
        while (pending_row.size() != 0 && drain_cycles < DRAIN_TIMEOUT) begin
            @(posedge clk_i);
            drain_cycles++;
        end
        if (pending_row.size() != 0) begin
            $display("timeout waiting for result");
            error_count++;
        end
        @(posedge clk_i);
        $display("%0d errors in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
